// File: list.f
logic/ts_map_pkg.sv
logic/sync_fifo.sv
logic/frame_steer.sv
logic/channel_buffer.sv
logic/frame_queue.sv
logic/frame_output.sv
logic/ts_map_top.sv
verification/ts_map_props.sv
verification/ts_map_tb.sv

// File: Bender.yml
package:
  name: ts_map

sources:
  - files:
      - logic/ts_map_pkg.sv
      - logic/sync_fifo.sv
      - logic/frame_steer.sv
      - logic/channel_buffer.sv
      - logic/frame_queue.sv
      - logic/frame_output.sv
      - logic/ts_map_top.sv
  - target: test
    files:
      - verification/ts_map_props.sv
      - verification/ts_map_tb.sv

// File: verification/ts_map_tb.sv
`timescale 1ns/10ps

module ts_map_tb import ts_map_pkg::*; ();

   localparam int unsigned NUM_FRAMES     = 200;
   // Last frames all go back to back to one channel
   localparam int unsigned BURST_START    = 160;
   localparam chan_t       BURST_CHAN     = 2'd2;
   localparam int unsigned TIMEOUT_CYCLES = NUM_FRAMES * 20 + 1000;

   logic  payload_clk = 1'b0;
   logic  payload_rst;
   logic  in_valid;
   logic  in_start;
   logic  in_end;
   word_t in_data;
   logic  in_ready;
   logic  out_valid;
   logic  out_start;
   logic  out_end;
   word_t out_data;

   // Reference model of words in input order plus frame lengths
   word_t       exp_words [$];
   int unsigned exp_lens [$];
   int unsigned in_count;
   int unsigned out_pos;
   int unsigned frames_seen;
   int unsigned stall_cycles;
   logic        burst_phase;
   logic        in_reset_q;
   logic        end_taken_q;
   logic [15:0] lfsr_state;

   ts_map_top i_ts_map_top (
      .payload_clk (payload_clk),
      .payload_rst (payload_rst),
      .in_valid    (in_valid),
      .in_start    (in_start),
      .in_end      (in_end),
      .in_data     (in_data),
      .in_ready    (in_ready),
      .out_valid   (out_valid),
      .out_start   (out_start),
      .out_end     (out_end),
      .out_data    (out_data)
   );

   always #5 payload_clk = ~payload_clk;

   // ----------------------------------------
   // Helpers
   // ----------------------------------------

   // 16-bit Fibonacci LFSR on taps 16 14 13 11
   // One step per bit taken
   function automatic logic [31:0] random_bits(input int unsigned n);
      logic [31:0] value;
      logic        fb;
      value = '0;
      for (int i = 0; i < n; i++)
      begin
         fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
         lfsr_state = {lfsr_state[14:0], fb};
         value      = {value[30:0], fb};
      end
      return value;
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp)
      begin
         fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_marker(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   // Send one frame and hold each word until the DUT takes it
   task automatic send_frame(input chan_t chan, input int unsigned len, input int unsigned gap);
      logic took;
      for (int w = 0; w < len; w++)
      begin
         in_valid = 1'b1;
         in_start = (w == 0);
         in_end   = (w == len - 1);
         in_data  = random_bits(32);
         if (w == 0)
         begin
            in_data[CHAN_MSB -: CHAN_WIDTH] = chan;
         end
         // in_ready comes from registered state and is stable at the falling edge
         do
         begin
            @(negedge payload_clk);
            took = in_ready;
            @(posedge payload_clk);
            #1;
         end while (!took);
      end
      in_valid = 1'b0;
      in_start = 1'b0;
      in_end   = 1'b0;
      repeat (gap)
      begin
         @(posedge payload_clk);
         #1;
      end
   endtask

   // ----------------------------------------
   // Monitor and model
   // ----------------------------------------
   always @(negedge payload_clk)
   begin
      if (payload_rst)
      begin
         check_marker("in_ready", in_ready, 1'b0);
         check_marker("out_valid", out_valid, 1'b0);
         check_marker("out_start", out_start, 1'b0);
         check_marker("out_end", out_end, 1'b0);
         in_reset_q = 1'b1;
      end
      else
      begin
         // Ready gap right after reset and after each end word
         if (in_reset_q || end_taken_q)
         begin
            check_marker("in_ready", in_ready, 1'b0);
         end
         if (in_valid && in_ready)
         begin
            exp_words.push_back(in_data);
            in_count++;
            if (in_end)
            begin
               exp_lens.push_back(in_count);
               in_count = 0;
            end
         end
         else if (in_valid && burst_phase && !end_taken_q)
         begin
            stall_cycles++;
         end
         // Output side follows input order
         if (out_valid)
         begin
            if (exp_words.size() == 0 || exp_lens.size() == 0)
            begin
               fail_run("Output word appeared with no matching input word");
            end
            else
            begin
               check_word("out_data", out_data, exp_words.pop_front());
               check_marker("out_start", out_start, out_pos == 0);
               check_marker("out_end", out_end, out_pos == exp_lens[0] - 1);
               if (out_end)
               begin
                  void'(exp_lens.pop_front());
                  out_pos = 0;
                  frames_seen++;
               end
               else
               begin
                  out_pos++;
               end
            end
         end
         else
         begin
            check_marker("out_start", out_start, 1'b0);
            check_marker("out_end", out_end, 1'b0);
            if (out_pos != 0)
            begin
               fail_run("out_valid dropped in the middle of a frame");
            end
         end
         end_taken_q = in_valid && in_ready && in_end;
         in_reset_q  = 1'b0;
      end
   end

   // ----------------------------------------
   // Stimulus
   // ----------------------------------------
   initial
   begin
      int unsigned len;
      int unsigned gap;
      chan_t       chan;
      lfsr_state   = 16'd10;
      payload_rst  = 1'b0;
      in_valid     = 1'b0;
      in_start     = 1'b0;
      in_end       = 1'b0;
      in_data      = '0;
      in_count     = 0;
      out_pos      = 0;
      frames_seen  = 0;
      stall_cycles = 0;
      burst_phase  = 1'b0;
      in_reset_q   = 1'b1;
      end_taken_q  = 1'b0;
      #1;
      payload_rst = 1'b1;
      repeat (10) @(posedge payload_clk);
      #1;
      payload_rst = 1'b0;
      for (int f = 0; f < NUM_FRAMES; f++)
      begin
         burst_phase = (f >= BURST_START);
         len         = random_bits(3) + 1;
         if (burst_phase)
         begin
            chan = BURST_CHAN;
            gap  = 0;
         end
         else
         begin
            chan = chan_t'(random_bits(CHAN_WIDTH));
            gap  = random_bits(2);
         end
         send_frame(chan, len, gap);
      end
      wait (frames_seen == NUM_FRAMES);
      // Room for stray output after the last frame
      repeat (20) @(posedge payload_clk);
      if (stall_cycles == 0)
      begin
         fail_run("in_ready never dropped during the same-channel burst");
      end
      else
      begin
         $display("Test completed successfully");
         $finish;
      end
   end

   // Watchdog sized from the frame count
   initial
   begin
      repeat (TIMEOUT_CYCLES) @(posedge payload_clk);
      fail_run($sformatf("Timeout after %0d cycles with %0d of %0d frames out",
                         TIMEOUT_CYCLES, frames_seen, NUM_FRAMES));
   end

endmodule

// File: verification/ts_map_props.sv
`timescale 1ns/10ps

module ts_map_props (
   input logic payload_clk,
   input logic payload_rst,
   input logic in_valid,
   input logic in_end,
   input logic in_ready,
   input logic out_valid,
   input logic out_start,
   input logic out_end
);

   // ----------------------------------------
   // Input handshake
   // ----------------------------------------

   // Gap cycle after every accepted end word
   a_ready_gap : assert property (@(posedge payload_clk) disable iff (payload_rst)
      (in_valid && in_ready && in_end) |=> !in_ready)
      else $error("in_ready high in the cycle after an accepted end word");

   // Quiet ports while in reset
   a_reset_quiet : assert property (@(posedge payload_clk)
      payload_rst |-> (!in_ready && !out_valid && !out_start && !out_end))
      else $error("Port active during reset");

   // ----------------------------------------
   // Output markers
   // ----------------------------------------
   a_start_valid : assert property (@(posedge payload_clk) out_start |-> out_valid)
      else $error("out_start without out_valid");

   a_end_valid : assert property (@(posedge payload_clk) out_end |-> out_valid)
      else $error("out_end without out_valid");

endmodule

bind ts_map_top ts_map_props i_ts_map_props (.*);

// File: logic/ts_map_top.sv
`timescale 1ns/10ps

module ts_map_top import ts_map_pkg::*; (
   input  logic  payload_clk,
   input  logic  payload_rst,
   input  logic  in_valid,
   input  logic  in_start,
   input  logic  in_end,
   input  word_t in_data,
   output logic  in_ready,
   output logic  out_valid,
   output logic  out_start,
   output logic  out_end,
   output word_t out_data
);

   // Steer to buffers
   logic [NUM_CHANNELS-1:0] wr_en;
   logic                    wr_start;
   logic                    wr_end;
   word_t                   wr_data;
   logic [NUM_CHANNELS-1:0] slot_free;

   // Buffers to queue
   logic [NUM_CHANNELS-1:0] done_req;
   slot_t                   done_slot [NUM_CHANNELS];
   len_t                    done_len [NUM_CHANNELS];
   logic [NUM_CHANNELS-1:0] done_ack;

   // Queue to output, output to buffers
   queue_entry_t            head;
   logic                    empty;
   logic                    pop;
   chan_t                   rd_chan;
   slot_t                   rd_slot;
   len_t                    rd_index;
   word_t                   rd_data [NUM_CHANNELS];
   logic [NUM_CHANNELS-1:0] release_en;
   slot_t                   release_slot;

   frame_steer i_frame_steer (
      .payload_clk (payload_clk),
      .payload_rst (payload_rst),
      .in_valid    (in_valid),
      .in_start    (in_start),
      .in_end      (in_end),
      .in_data     (in_data),
      .in_ready    (in_ready),
      .slot_free   (slot_free),
      .wr_en       (wr_en),
      .wr_start    (wr_start),
      .wr_end      (wr_end),
      .wr_data     (wr_data)
   );

   // One buffer per channel, shared write and read buses
   for (genvar i = 0; i < NUM_CHANNELS; i++)
   begin : g_buffer
      channel_buffer i_channel_buffer (
         .payload_clk  (payload_clk),
         .payload_rst  (payload_rst),
         .wr_en        (wr_en[i]),
         .wr_start     (wr_start),
         .wr_end       (wr_end),
         .wr_data      (wr_data),
         .slot_free    (slot_free[i]),
         .done_req     (done_req[i]),
         .done_slot    (done_slot[i]),
         .done_len     (done_len[i]),
         .done_ack     (done_ack[i]),
         .rd_slot      (rd_slot),
         .rd_index     (rd_index),
         .rd_data      (rd_data[i]),
         .release_en   (release_en[i]),
         .release_slot (release_slot)
      );
   end

   frame_queue i_frame_queue (
      .payload_clk (payload_clk),
      .payload_rst (payload_rst),
      .done_req    (done_req),
      .done_slot   (done_slot),
      .done_len    (done_len),
      .done_ack    (done_ack),
      .pop         (pop),
      .head        (head),
      .empty       (empty)
   );

   frame_output i_frame_output (
      .payload_clk  (payload_clk),
      .payload_rst  (payload_rst),
      .head         (head),
      .empty        (empty),
      .pop          (pop),
      .rd_chan      (rd_chan),
      .rd_slot      (rd_slot),
      .rd_index     (rd_index),
      .rd_data      (rd_data),
      .release_en   (release_en),
      .release_slot (release_slot),
      .out_valid    (out_valid),
      .out_start    (out_start),
      .out_end      (out_end),
      .out_data     (out_data)
   );

endmodule

// File: logic/frame_output.sv
`timescale 1ns/10ps

module frame_output import ts_map_pkg::*; (
   input  logic                    payload_clk,
   input  logic                    payload_rst,
   input  queue_entry_t            head,
   input  logic                    empty,
   output logic                    pop,
   output chan_t                   rd_chan,
   output slot_t                   rd_slot,
   output len_t                    rd_index,
   input  word_t                   rd_data [NUM_CHANNELS],
   output logic [NUM_CHANNELS-1:0] release_en,
   output slot_t                   release_slot,
   output logic                    out_valid,
   output logic                    out_start,
   output logic                    out_end,
   output word_t                   out_data
);

   typedef enum logic [1:0] {IDLE, POP, REGISTER, DRIVE} pop_state_t;

   pop_state_t state;
   pop_state_t next_state;
   len_t       len_q;
   logic       drive;
   logic       last_word;

   assign drive     = (state == DRIVE);
   assign last_word = (rd_index == len_q);

   // ----------------------------------------
   // Pop FSM
   // ----------------------------------------
   always_comb
   begin
      case (state)
         IDLE:     next_state = empty ? IDLE : POP;
         POP:      next_state = REGISTER;
         REGISTER: next_state = DRIVE;
         // Straight into the next pop when more frames wait
         DRIVE:    next_state = !last_word ? DRIVE : (empty ? IDLE : POP);
         default:  next_state = IDLE;
      endcase
   end

   always_ff @(posedge payload_clk or posedge payload_rst)
   begin
      if (payload_rst)
      begin
         state <= IDLE;
      end
      else
      begin
         state <= next_state;
      end
   end

   assign pop = (state == POP);

   // Read addressing from the head entry, word count in DRIVE
   always_ff @(posedge payload_clk or posedge payload_rst)
   begin
      if (payload_rst)
      begin
         rd_chan  <= '0;
         rd_slot  <= '0;
         rd_index <= '0;
         len_q    <= '0;
      end
      else if (state == REGISTER)
      begin
         rd_chan  <= head.chan;
         rd_slot  <= head.slot;
         rd_index <= '0;
         len_q    <= head.len;
      end
      else if (drive)
      begin
         rd_index <= rd_index + len_t'(1);
      end
   end

   // Slot freed as its last word is taken
   always_comb
   begin
      release_en = '0;
      release_en[rd_chan] = drive && last_word;
   end
   assign release_slot = rd_slot;

   // ----------------------------------------
   // Registered output mux
   // ----------------------------------------
   always_ff @(posedge payload_clk or posedge payload_rst)
   begin
      if (payload_rst)
      begin
         out_valid <= 1'b0;
         out_start <= 1'b0;
         out_end   <= 1'b0;
      end
      else
      begin
         out_valid <= drive;
         out_start <= drive && (rd_index == '0);
         out_end   <= drive && last_word;
      end
   end

   always_ff @(posedge payload_clk)
   begin
      out_data <= rd_data[rd_chan];
   end

endmodule

// File: logic/frame_queue.sv
`timescale 1ns/10ps

module frame_queue import ts_map_pkg::*; (
   input  logic                    payload_clk,
   input  logic                    payload_rst,
   input  logic [NUM_CHANNELS-1:0] done_req,
   input  slot_t                   done_slot [NUM_CHANNELS],
   input  len_t                    done_len [NUM_CHANNELS],
   output logic [NUM_CHANNELS-1:0] done_ack,
   input  logic                    pop,
   output queue_entry_t            head,
   output logic                    empty
);

   typedef enum logic {IDLE, PUSH} push_state_t;

   push_state_t  state;
   chan_t        grant_c;
   chan_t        grant_q;
   logic         push;
   logic         full;
   queue_entry_t wr_entry;

   // ----------------------------------------
   // Priority arbiter, lowest index wins
   // ----------------------------------------
   always_comb
   begin
      grant_c = '0;
      for (int c = NUM_CHANNELS - 1; c >= 0; c--)
      begin
         if (done_req[c])
         begin
            grant_c = chan_t'(c);
         end
      end
   end

   // ----------------------------------------
   // Push FSM
   // ----------------------------------------

   // Winner latched in IDLE, pushed in PUSH
   always_ff @(posedge payload_clk or posedge payload_rst)
   begin
      if (payload_rst)
      begin
         state   <= IDLE;
         grant_q <= '0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               grant_q <= grant_c;
               if ((|done_req) && !full)
               begin
                  state <= PUSH;
               end
            end
            default:
            begin
               state <= IDLE;
            end
         endcase
      end
   end

   assign push = (state == PUSH);

   // Ack the granted buffer during the push
   always_comb
   begin
      done_ack = '0;
      done_ack[grant_q] = push;
   end

   // Arbiter position is the channel index
   assign wr_entry.chan = grant_q;
   assign wr_entry.slot = done_slot[grant_q];
   assign wr_entry.len  = done_len[grant_q];

   sync_fifo #(
      .entry_t (queue_entry_t),
      .DEPTH   (QUEUE_DEPTH)
   ) i_sync_fifo (
      .payload_clk (payload_clk),
      .payload_rst (payload_rst),
      .push        (push),
      .pop         (pop),
      .wr_entry    (wr_entry),
      .rd_entry    (head),
      .empty       (empty),
      .full        (full)
   );

endmodule

// File: logic/channel_buffer.sv
`timescale 1ns/10ps

module channel_buffer import ts_map_pkg::*; (
   input  logic  payload_clk,
   input  logic  payload_rst,
   input  logic  wr_en,
   input  logic  wr_start,
   input  logic  wr_end,
   input  word_t wr_data,
   output logic  slot_free,
   output logic  done_req,
   output slot_t done_slot,
   output len_t  done_len,
   input  logic  done_ack,
   input  slot_t rd_slot,
   input  len_t  rd_index,
   output word_t rd_data,
   input  logic  release_en,
   input  slot_t release_slot
);

   // Frame store, slot by word
   word_t                        mem [SLOTS_PER_CHANNEL][MAX_FRAME_WORDS];
   logic [SLOTS_PER_CHANNEL-1:0] busy;
   logic                         open;
   slot_t                        wr_slot;
   len_t                         wr_index;
   slot_t                        free_slot;
   slot_t                        cur_slot;
   len_t                         cur_index;

   // Lowest free slot
   always_comb
   begin
      free_slot = '0;
      for (int s = SLOTS_PER_CHANNEL - 1; s >= 0; s--)
      begin
         if (!busy[s])
         begin
            free_slot = slot_t'(s);
         end
      end
   end

   // Start word restarts addressing in a fresh slot
   assign cur_slot  = wr_start ? free_slot : wr_slot;
   assign cur_index = wr_start ? '0 : wr_index;

   // Room for a new frame, or a frame still being written here
   assign slot_free = !(&busy) || open;

   // ----------------------------------------
   // Slot state and completion request
   // ----------------------------------------
   always_ff @(posedge payload_clk or posedge payload_rst)
   begin
      if (payload_rst)
      begin
         busy     <= '0;
         open     <= 1'b0;
         wr_slot  <= '0;
         wr_index <= '0;
         done_req <= 1'b0;
      end
      else
      begin
         // Slot handed back after readout
         if (release_en)
         begin
            busy[release_slot] <= 1'b0;
         end
         if (done_ack)
         begin
            done_req <= 1'b0;
         end
         if (wr_en)
         begin
            wr_slot  <= cur_slot;
            wr_index <= cur_index + len_t'(1);
            if (wr_start)
            begin
               busy[free_slot] <= 1'b1;
            end
            open <= !wr_end;
            // Complete frame, announce to arbiter
            if (wr_end)
            begin
               done_req <= 1'b1;
            end
         end
      end
   end

   // Store word, capture slot and length of a finished frame
   always_ff @(posedge payload_clk)
   begin
      if (wr_en)
      begin
         mem[cur_slot][cur_index] <= wr_data;
         if (wr_end)
         begin
            done_slot <= cur_slot;
            done_len  <= cur_index;
         end
      end
   end

   // Asynchronous read for the output stage
   assign rd_data = mem[rd_slot][rd_index];

endmodule

// File: logic/frame_steer.sv
`timescale 1ns/10ps

module frame_steer import ts_map_pkg::*; (
   input  logic                    payload_clk,
   input  logic                    payload_rst,
   input  logic                    in_valid,
   input  logic                    in_start,
   input  logic                    in_end,
   input  word_t                   in_data,
   output logic                    in_ready,
   input  logic [NUM_CHANNELS-1:0] slot_free,
   output logic [NUM_CHANNELS-1:0] wr_en,
   output logic                    wr_start,
   output logic                    wr_end,
   output word_t                   wr_data
);

   logic  accept;
   logic  ready_hold;
   chan_t chan_q;
   chan_t sel_chan;

   // ----------------------------------------
   // Input handshake
   // ----------------------------------------

   // Held low in the gap after an end word, and for one cycle out of reset
   assign in_ready = !ready_hold && (&slot_free);
   assign accept   = in_valid && in_ready;

   // Start word carries its own channel, later words use the captured one
   assign sel_chan = in_start ? in_data[CHAN_MSB -: CHAN_WIDTH] : chan_q;

   always_ff @(posedge payload_clk or posedge payload_rst)
   begin
      if (payload_rst)
      begin
         ready_hold <= 1'b1;
         chan_q     <= '0;
      end
      else
      begin
         ready_hold <= accept && in_end;
         if (accept && in_start)
         begin
            chan_q <= sel_chan;
         end
      end
   end

   // ----------------------------------------
   // Buffer write port
   // ----------------------------------------

   // One-hot write strobe, a cycle after acceptance
   always_ff @(posedge payload_clk or posedge payload_rst)
   begin
      if (payload_rst)
      begin
         wr_en <= '0;
      end
      else
      begin
         wr_en <= '0;
         if (accept)
         begin
            wr_en[sel_chan] <= 1'b1;
         end
      end
   end

   // Word and markers, qualified by wr_en downstream
   always_ff @(posedge payload_clk)
   begin
      if (accept)
      begin
         wr_start <= in_start;
         wr_end   <= in_end;
         wr_data  <= in_data;
      end
   end

endmodule

// File: logic/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
   parameter type entry_t = logic,
   parameter int unsigned DEPTH = 8
) (
   input  logic   payload_clk,
   input  logic   payload_rst,
   input  logic   push,
   input  logic   pop,
   input  entry_t wr_entry,
   output entry_t rd_entry,
   output logic   empty,
   output logic   full
);

   // Entry storage
   entry_t                   mem [DEPTH];
   logic [$clog2(DEPTH)-1:0] wr_ptr;
   logic [$clog2(DEPTH)-1:0] rd_ptr;
   logic [$clog2(DEPTH+1)-1:0] count;
   logic                     do_push;
   logic                     do_pop;

   // Ignore push when full, pop when empty
   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   assign empty = (count == '0);
   assign full  = (count == DEPTH);

   // Pointers and fill level
   always_ff @(posedge payload_clk or posedge payload_rst)
   begin
      if (payload_rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
         begin
            wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop)
         begin
            rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         end
         if (do_push && !do_pop)
         begin
            count <= count + 1'b1;
         end
         else if (do_pop && !do_push)
         begin
            count <= count - 1'b1;
         end
      end
   end

   // Storage write and registered head, valid the cycle after pop
   always_ff @(posedge payload_clk)
   begin
      if (do_push)
      begin
         mem[wr_ptr] <= wr_entry;
      end
      if (do_pop)
      begin
         rd_entry <= mem[rd_ptr];
      end
   end

endmodule

// File: logic/ts_map_pkg.sv
package ts_map_pkg;

   // ----------------------------------------
   // Sizes
   // ----------------------------------------

   // Channel buffers, one per channel index
   localparam int unsigned NUM_CHANNELS      = 4;
   localparam int unsigned CHAN_WIDTH        = 2;
   // Channel field sits at the top of the start word
   localparam int unsigned CHAN_MSB          = 31;

   // Frame slots per buffer
   localparam int unsigned SLOTS_PER_CHANNEL = 2;
   localparam int unsigned SLOT_WIDTH        = 1;

   // Frame length limits, length stored minus one
   localparam int unsigned MAX_FRAME_WORDS   = 8;
   localparam int unsigned LEN_WIDTH         = 3;

   // Room for every slot of every channel
   localparam int unsigned QUEUE_DEPTH       = 8;

   // ----------------------------------------
   // Types
   // ----------------------------------------
   typedef logic [31:0]           word_t;
   typedef logic [CHAN_WIDTH-1:0] chan_t;
   typedef logic [SLOT_WIDTH-1:0] slot_t;
   typedef logic [LEN_WIDTH-1:0]  len_t;

   // Pointer queue entry, 6 bits
   typedef struct packed {
      chan_t chan;
      slot_t slot;
      len_t  len;
   } queue_entry_t;

endpackage
